/* hw/rp_settings.svh */
// analog front end settings
// sample widths, channel counts, PDM range and the
// identification word shared by the whole front end

`ifndef RP_SETTINGS_SVH
`define RP_SETTINGS_SVH

// ADC and DAC channel count
`define RP_CHN      2
// raw ADC word and oscilloscope sample width
`define RP_ADC_DW   16
// generator sample and DAC code width
`define RP_DAC_DW   14
// expansion connector width, P and N rows together
`define RP_GPIO_DW  16
// PDM outputs
`define RP_PDM_CHN  4
`define RP_PDM_DW   8
`define RP_PDM_RNG  255
// identification word, read-only
`define RP_ID_VALUE 32'h5250_0a01

`endif

/* hw/rp_sample_pkg.sv */
// sample and code types
// data words on the ADC, DAC, expansion and PDM paths

`include "rp_settings.svh"

package rp_sample_pkg;

  //////////////////////
  // analog paths
  //////////////////////

  // oscilloscope sample, two's complement
  typedef logic signed [`RP_ADC_DW-1:0] adc_smp_t;
  // raw ADC word, inverted slope
  typedef logic [`RP_ADC_DW-1:0] adc_raw_t;
  // generator sample, two's complement
  typedef logic signed [`RP_DAC_DW-1:0] gen_smp_t;
  // DAC code, inverted slope
  typedef logic [`RP_DAC_DW-1:0] dac_code_t;

  //////////////////////
  // digital paths
  //////////////////////

  // one bit per expansion pin
  typedef logic [`RP_GPIO_DW-1:0] gpio_vec_t;
  // PDM level, counts of ones per range period
  typedef logic [`RP_PDM_DW-1:0] pdm_lvl_t;

endpackage : rp_sample_pkg

/* hw/rp_mgmt_pkg.sv */
// management register map
// register addresses and the bus data word
// of the front end register set

package rp_mgmt_pkg;

  //////////////////////
  // address map
  //////////////////////

  // address 3 is unused and reads zero
  typedef enum logic [2:0] {
    // identification, constant
    REG_ID   = 3'd0,
    // per channel DAC to ADC loopback, 2 bits
    REG_LOOP = 3'd1,
    // expansion mode per pin, 16 bits
    REG_IOM  = 3'd2,
    // PDM levels, 8 bits each
    REG_PDM0 = 3'd4,
    REG_PDM1 = 3'd5,
    REG_PDM2 = 3'd6,
    REG_PDM3 = 3'd7
  } reg_addr_e;

  //////////////////////
  // data
  //////////////////////

  // narrower registers are zero extended on read
  typedef logic [31:0] reg_data_t;

endpackage : rp_mgmt_pkg

/* hw/osc_input_path.sv */
// oscilloscope input path, one channel
// registers the raw ADC word, converts the inverted slope
// code into two's complement and selects the generator
// loopback sample when the channel is looped

`timescale 1ns/1ps
`include "rp_settings.svh"

module osc_input_path (
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // ADC pins
  input  rp_sample_pkg::adc_raw_t adc_dat_i,
  // loopback control
  input  logic                    loop_i,
  // generator stream
  input  rp_sample_pkg::gen_smp_t gen_dat_i,
  input  logic                    gen_vld_i,
  // oscilloscope stream
  output rp_sample_pkg::adc_smp_t osc_dat_o,
  output logic                    osc_vld_o
);

  import rp_sample_pkg::*;

  // input register, ideally packed into the IO block
  adc_raw_t adc_raw;
  // converted ADC sample
  adc_smp_t adc_smp;
  // generator sample scaled up to the ADC width
  adc_smp_t gen_smp;

  //////////////////////
  // ADC capture
  //////////////////////

  always_ff @(posedge adc_clk) begin
    adc_raw <= adc_dat_i;
  end

  // negative slope, keep sign and flip the rest
  assign adc_smp = {adc_raw[`RP_ADC_DW-1], ~adc_raw[`RP_ADC_DW-2:0]};

  // 14 bit generator into 16 bit scope, shift by two
  assign gen_smp = {gen_dat_i, {(`RP_ADC_DW-`RP_DAC_DW){1'b0}}};

  //////////////////////
  // loopback mux
  //////////////////////

  // valid follows the selected source
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      osc_vld_o <= 1'b0;
    end else begin
      osc_vld_o <= loop_i ? gen_vld_i : 1'b1;
    end
  end

  // sample register
  always_ff @(posedge adc_clk) begin
    osc_dat_o <= loop_i ? gen_smp : adc_smp;
  end

endmodule : osc_input_path

/* hw/dac_output_path.sv */
// DAC output path, one channel
// converts signed generator samples into inverted slope
// DAC codes, starts at midscale and holds while looped

`timescale 1ns/1ps
`include "rp_settings.svh"

module dac_output_path (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  // loopback control
  input  logic                     loop_i,
  // generator stream
  input  rp_sample_pkg::gen_smp_t  gen_dat_i,
  input  logic                     gen_vld_i,
  // DAC pins
  output rp_sample_pkg::dac_code_t dac_dat_o
);

  import rp_sample_pkg::*;

  // midscale code, matches a zero sample
  localparam dac_code_t DAC_MID = dac_code_t'((1 << (`RP_DAC_DW-1)) - 1);

  // converted generator sample
  dac_code_t dac_code;
  // load enable
  logic      dac_load;

  //////////////////////
  // conversion
  //////////////////////

  // signed to negative slope unsigned
  assign dac_code = {gen_dat_i[`RP_DAC_DW-1], ~gen_dat_i[`RP_DAC_DW-2:0]};

  // looped samples go to the scope instead
  assign dac_load = gen_vld_i & ~loop_i;

  //////////////////////
  // output register
  //////////////////////

  // stands in for the DDR output register
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= DAC_MID;
    end else if (dac_load) begin
      dac_dat_o <= dac_code;
    end
  end

endmodule : dac_output_path

/* hw/mgmt_regs.sv */
// management register set
// identification, loopback, expansion mode and PDM levels
// written with a one cycle strobe, read back one cycle
// after the read strobe with a single cycle ack

`timescale 1ns/1ps
`include "rp_settings.svh"

module mgmt_regs (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  // register bus
  input  logic                                      bus_wr_i,
  input  logic                                      bus_rd_i,
  input  rp_mgmt_pkg::reg_addr_e                    bus_addr_i,
  input  rp_mgmt_pkg::reg_data_t                    bus_wdata_i,
  output rp_mgmt_pkg::reg_data_t                    bus_rdata_o,
  output logic                                      bus_ack_o,
  // configuration outputs
  output logic [`RP_CHN-1:0]                        loop_sel_o,
  output rp_sample_pkg::gpio_vec_t                  exp_iom_o,
  output rp_sample_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0] pdm_lvl_o
);

  import rp_mgmt_pkg::*;

  // PDM registers sit on consecutive addresses
  localparam int unsigned PDM_AW = $clog2(`RP_PDM_CHN);

  // read data before the output register
  reg_data_t rd_mux;

  //////////////////////
  // write decode
  //////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_sel_o <= '0;
      exp_iom_o  <= '0;
      pdm_lvl_o  <= '0;
    end else if (bus_wr_i) begin
      case (bus_addr_i)
        REG_LOOP: loop_sel_o <= bus_wdata_i[`RP_CHN-1:0];
        REG_IOM:  exp_iom_o  <= bus_wdata_i[`RP_GPIO_DW-1:0];
        REG_PDM0, REG_PDM1, REG_PDM2, REG_PDM3: begin
          pdm_lvl_o[bus_addr_i[PDM_AW-1:0]] <= bus_wdata_i[`RP_PDM_DW-1:0];
        end
        // identification is read only, hole ignored
        default: ;
      endcase
    end
  end

  //////////////////////
  // read back
  //////////////////////

  // zero extend narrow registers
  always_comb begin
    case (bus_addr_i)
      REG_ID:   rd_mux = `RP_ID_VALUE;
      REG_LOOP: rd_mux = reg_data_t'(loop_sel_o);
      REG_IOM:  rd_mux = reg_data_t'(exp_iom_o);
      REG_PDM0, REG_PDM1, REG_PDM2, REG_PDM3: begin
        rd_mux = reg_data_t'(pdm_lvl_o[bus_addr_i[PDM_AW-1:0]]);
      end
      default:  rd_mux = '0;
    endcase
  end

  // ack one cycle after the strobe, data held until the next read
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      bus_ack_o   <= 1'b0;
      bus_rdata_o <= '0;
    end else begin
      bus_ack_o <= bus_rd_i;
      if (bus_rd_i) begin
        bus_rdata_o <= rd_mux;
      end
    end
  end

endmodule : mgmt_regs

/* hw/exp_gpio_mux.sv */
// expansion connector mux
// per pin choice between processor GPIO and the logic
// generator, registered output and tristate, two stage
// input register back towards the processor

`timescale 1ns/1ps
`include "rp_settings.svh"

module exp_gpio_mux (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  // mode per pin, 0 processor, 1 logic generator
  input  rp_sample_pkg::gpio_vec_t iom_i,
  // processor GPIO, t high means tristate
  input  rp_sample_pkg::gpio_vec_t gpio_o_i,
  input  rp_sample_pkg::gpio_vec_t gpio_t_i,
  // logic generator, e high means drive
  input  rp_sample_pkg::gpio_vec_t lg_o_i,
  input  rp_sample_pkg::gpio_vec_t lg_e_i,
  // connector pins
  input  rp_sample_pkg::gpio_vec_t exp_i_i,
  output rp_sample_pkg::gpio_vec_t exp_o_o,
  output rp_sample_pkg::gpio_vec_t exp_t_o,
  // back to processor
  output rp_sample_pkg::gpio_vec_t gpio_i_o
);

  import rp_sample_pkg::*;

  // first input stage
  gpio_vec_t exp_i_q;

  //////////////////////
  // output and tristate
  //////////////////////

  // pins float after reset
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      exp_o_o <= '0;
      exp_t_o <= '1;
    end else begin
      exp_o_o <= (~iom_i & gpio_o_i) | (iom_i & lg_o_i);
      // enable from the generator turns into a tristate bit
      exp_t_o <= (~iom_i & gpio_t_i) | (iom_i & ~lg_e_i);
    end
  end

  //////////////////////
  // input stages
  //////////////////////

  always_ff @(posedge adc_clk) begin
    exp_i_q  <= exp_i_i;
    gpio_i_o <= exp_i_q;
  end

endmodule : exp_gpio_mux

/* hw/pdm_dac.sv */
// pulse density modulated DACs
// first order modulator per channel, the number of ones
// over one range period equals the programmed level

`timescale 1ns/1ps
`include "rp_settings.svh"

module pdm_dac (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  // levels from the register set
  input  rp_sample_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0] lvl_i,
  // modulator outputs
  output logic [`RP_PDM_CHN-1:0]                    pdm_o
);

  import rp_sample_pkg::*;

  // sum needs one carry bit above the level
  localparam int unsigned SUM_W = `RP_PDM_DW + 1;
  localparam logic [SUM_W-1:0] PDM_RNG = SUM_W'(`RP_PDM_RNG);

  // accumulators, always below the range
  pdm_lvl_t [`RP_PDM_CHN-1:0] acc;
  // accumulator plus level
  logic [`RP_PDM_CHN-1:0][SUM_W-1:0] sum;

  //////////////////////
  // adders
  //////////////////////

  always_comb begin
    for (int i = 0; i < `RP_PDM_CHN; i++) begin
      sum[i] = SUM_W'(acc[i]) + SUM_W'(lvl_i[i]);
    end
  end

  //////////////////////
  // modulators
  //////////////////////

  // free running, a new level counts from the next edge
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      acc   <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < `RP_PDM_CHN; i++) begin
        if (sum[i] >= PDM_RNG) begin
          // overflow, emit a one and wrap
          acc[i]   <= pdm_lvl_t'(sum[i] - PDM_RNG);
          pdm_o[i] <= 1'b1;
        end else begin
          acc[i]   <= pdm_lvl_t'(sum[i]);
          pdm_o[i] <= 1'b0;
        end
      end
    end
  end

endmodule : pdm_dac

/* hw/rp_analog_top.sv */
// analog and mixed signal front end
// ADC and DAC paths with loopback, expansion GPIO mux,
// PDM DACs and the management register set behind a
// plain strobe bus, all on the ADC clock

`timescale 1ns/1ps
`include "rp_settings.svh"

module rp_analog_top (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  // register bus
  input  logic                                      bus_wr_i,
  input  logic                                      bus_rd_i,
  input  rp_mgmt_pkg::reg_addr_e                    bus_addr_i,
  input  rp_mgmt_pkg::reg_data_t                    bus_wdata_i,
  output rp_mgmt_pkg::reg_data_t                    bus_rdata_o,
  output logic                                      bus_ack_o,
  // ADC pins
  input  rp_sample_pkg::adc_raw_t  [`RP_CHN-1:0]    adc_dat_i,
  // generator streams
  input  rp_sample_pkg::gen_smp_t  [`RP_CHN-1:0]    gen_dat_i,
  input  logic                     [`RP_CHN-1:0]    gen_vld_i,
  // oscilloscope streams
  output rp_sample_pkg::adc_smp_t  [`RP_CHN-1:0]    osc_dat_o,
  output logic                     [`RP_CHN-1:0]    osc_vld_o,
  // DAC codes, one word per channel
  output rp_sample_pkg::dac_code_t [`RP_CHN-1:0]    dac_dat_o,
  // processor GPIO and logic generator
  input  rp_sample_pkg::gpio_vec_t                  gpio_o_i,
  input  rp_sample_pkg::gpio_vec_t                  gpio_t_i,
  input  rp_sample_pkg::gpio_vec_t                  lg_o_i,
  input  rp_sample_pkg::gpio_vec_t                  lg_e_i,
  // expansion connector
  input  rp_sample_pkg::gpio_vec_t                  exp_i_i,
  output rp_sample_pkg::gpio_vec_t                  exp_o_o,
  output rp_sample_pkg::gpio_vec_t                  exp_t_o,
  output rp_sample_pkg::gpio_vec_t                  gpio_i_o,
  // PDM outputs
  output logic [`RP_PDM_CHN-1:0]                    pdm_o
);

  import rp_sample_pkg::*;

  // configuration from the register set
  logic [`RP_CHN-1:0]         loop_sel;
  gpio_vec_t                  exp_iom;
  pdm_lvl_t [`RP_PDM_CHN-1:0] pdm_lvl;

  ////////////////////
  // management
  ////////////////////

  mgmt_regs mgmt_regs_inst (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .bus_wr_i    (bus_wr_i),
    .bus_rd_i    (bus_rd_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rdata_o (bus_rdata_o),
    .bus_ack_o   (bus_ack_o),
    .loop_sel_o  (loop_sel),
    .exp_iom_o   (exp_iom),
    .pdm_lvl_o   (pdm_lvl)
  );

  ////////////////////
  // ADC and DAC
  ////////////////////

  // loop bit i routes generator i into scope i
  for (genvar i = 0; i < `RP_CHN; i++) begin : gen_chn
    osc_input_path osc_input_path_inst (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .adc_dat_i (adc_dat_i[i]),
      .loop_i    (loop_sel[i]),
      .gen_dat_i (gen_dat_i[i]),
      .gen_vld_i (gen_vld_i[i]),
      .osc_dat_o (osc_dat_o[i]),
      .osc_vld_o (osc_vld_o[i])
    );

    dac_output_path dac_output_path_inst (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .loop_i    (loop_sel[i]),
      .gen_dat_i (gen_dat_i[i]),
      .gen_vld_i (gen_vld_i[i]),
      .dac_dat_o (dac_dat_o[i])
    );
  end : gen_chn

  ////////////////////
  // expansion GPIO
  ////////////////////

  exp_gpio_mux exp_gpio_mux_inst (
    .adc_clk  (adc_clk),
    .top_rst  (top_rst),
    .iom_i    (exp_iom),
    .gpio_o_i (gpio_o_i),
    .gpio_t_i (gpio_t_i),
    .lg_o_i   (lg_o_i),
    .lg_e_i   (lg_e_i),
    .exp_i_i  (exp_i_i),
    .exp_o_o  (exp_o_o),
    .exp_t_o  (exp_t_o),
    .gpio_i_o (gpio_i_o)
  );

  ////////////////////
  // PDM
  ////////////////////

  pdm_dac pdm_dac_inst (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .lvl_i   (pdm_lvl),
    .pdm_o   (pdm_o)
  );

endmodule : rp_analog_top

/* tests/tb_rp_analog_top.sv */
// testbench for the analog front end top level
// stimulus on the falling edge from a fixed seed LCG,
// expected values from reference functions queued with
// their due cycle and compared after each rising edge

`timescale 1ns/1ps
`include "rp_settings.svh"

module tb_rp_analog_top;

  import rp_sample_pkg::*;
  import rp_mgmt_pkg::*;

  // roughly 1350 cycles of tests, plus margin
  localparam int TIMEOUT_CYCLES = 3000;
  // probe selectors, channel added where there are two
  localparam int SIG_OSC = 0;
  localparam int SIG_DAC = 2;
  localparam int SIG_EXP = 4;
  localparam int SIG_GPI = 5;
  localparam int SIG_BUS = 6;

  typedef logic [63:0] val_t;

  // DUT ports, named as on the top level
  logic                    adc_clk = 1'b0;
  logic                    top_rst;
  logic                    bus_wr_i;
  logic                    bus_rd_i;
  reg_addr_e               bus_addr_i;
  reg_data_t               bus_wdata_i;
  reg_data_t               bus_rdata_o;
  logic                    bus_ack_o;
  adc_raw_t  [`RP_CHN-1:0] adc_dat_i;
  gen_smp_t  [`RP_CHN-1:0] gen_dat_i;
  logic      [`RP_CHN-1:0] gen_vld_i;
  adc_smp_t  [`RP_CHN-1:0] osc_dat_o;
  logic      [`RP_CHN-1:0] osc_vld_o;
  dac_code_t [`RP_CHN-1:0] dac_dat_o;
  gpio_vec_t               gpio_o_i;
  gpio_vec_t               gpio_t_i;
  gpio_vec_t               lg_o_i;
  gpio_vec_t               lg_e_i;
  gpio_vec_t               exp_i_i;
  gpio_vec_t               exp_o_o;
  gpio_vec_t               exp_t_o;
  gpio_vec_t               gpio_i_o;
  logic [`RP_PDM_CHN-1:0]  pdm_o;

  // run state and models
  int                 cyc = 0;
  int                 errors = 0;
  int                 checks = 0;
  logic [31:0]        lcg_state = 32'hac50ffa8;
  logic [`RP_CHN-1:0] loop_now = '0;
  dac_code_t          dac_model [`RP_CHN];
  int                 level_tab [4] = '{0, 1, 128, 255};

  // expectations waiting for their cycle
  int    due_q [$];
  int    sig_q [$];
  val_t  exp_q [$];
  string name_q [$];

  rp_analog_top rp_analog_top_inst (.*);

  always #50 adc_clk = ~adc_clk;

  ////////////////////
  // reference rules
  ////////////////////

  // inverted slope word, sign bit kept, rest flipped
  function automatic logic [15:0] adc_to_osc(input logic [15:0] raw);
    return raw ^ 16'h7fff;
  endfunction

  function automatic logic [13:0] gen_to_dac(input logic [13:0] smp);
    return smp ^ 14'h1fff;
  endfunction

  // signed sample times four in the scope width
  function automatic logic [15:0] gen_to_osc(input logic [13:0] smp);
    int v;
    v = $signed(smp);
    v = v * 4;
    return v[15:0];
  endfunction

  // mode bit 1 takes the logic generator value
  function automatic gpio_vec_t pin_select(input gpio_vec_t iom, input gpio_vec_t cpu,
                                           input gpio_vec_t lg);
    gpio_vec_t r;
    for (int b = 0; b < `RP_GPIO_DW; b++) begin
      r[b] = iom[b] ? lg[b] : cpu[b];
    end
    return r;
  endfunction

  // read back of a register after writing wd
  function automatic reg_data_t reg_expect(input int addr, input reg_data_t wd);
    case (addr)
      0:          return `RP_ID_VALUE;
      1:          return wd & 32'h0000_0003;
      2:          return wd & 32'h0000_ffff;
      4, 5, 6, 7: return wd & 32'h0000_00ff;
      default:    return '0;
    endcase
  endfunction

  function automatic int count_ones(input logic [`RP_PDM_RNG-1:0] hist);
    int n;
    n = 0;
    for (int b = 0; b < `RP_PDM_RNG; b++) begin
      n += hist[b];
    end
    return n;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  ////////////////////
  // checking
  ////////////////////

  function automatic val_t probe(input int sig);
    case (sig)
      SIG_OSC, SIG_OSC + 1: return {osc_vld_o[sig - SIG_OSC], osc_dat_o[sig - SIG_OSC]};
      SIG_DAC, SIG_DAC + 1: return dac_dat_o[sig - SIG_DAC];
      SIG_EXP: return {exp_t_o, exp_o_o};
      SIG_GPI: return gpio_i_o;
      default: return {bus_ack_o, bus_rdata_o};
    endcase
  endfunction

  task automatic check_value(input string name, input val_t exp_v, input val_t act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  // lat rising edges after the current falling edge
  task automatic expect_at(input int lat, input int sig, input val_t v, input string name);
    due_q.push_back(cyc + lat);
    sig_q.push_back(sig);
    exp_q.push_back(v);
    name_q.push_back(name);
  endtask

  always @(posedge adc_clk) begin : compare
    int i;
    cyc = cyc + 1;
    // outputs settled after the edge
    #1;
    i = 0;
    while (i < due_q.size()) begin
      if (due_q[i] == cyc) begin
        check_value(name_q[i], exp_q[i], probe(sig_q[i]));
        due_q.delete(i);
        sig_q.delete(i);
        exp_q.delete(i);
        name_q.delete(i);
      end else begin
        i++;
      end
    end
  end

  ////////////////////
  // stimulus tasks
  ////////////////////

  task automatic bus_write(input int addr, input reg_data_t wd);
    @(negedge adc_clk);
    bus_wr_i    = 1'b1;
    bus_addr_i  = reg_addr_e'(addr);
    bus_wdata_i = wd;
    @(negedge adc_clk);
    bus_wr_i = 1'b0;
  endtask

  // ack for exactly one cycle, read data held after it
  task automatic bus_read(input int addr, input reg_data_t exp_v, input string name);
    @(negedge adc_clk);
    bus_rd_i   = 1'b1;
    bus_addr_i = reg_addr_e'(addr);
    expect_at(1, SIG_BUS, {1'b1, exp_v}, name);
    expect_at(2, SIG_BUS, {1'b0, exp_v}, {name, " ack end"});
    @(negedge adc_clk);
    bus_rd_i = 1'b0;
  endtask

  task automatic set_loop(input logic [`RP_CHN-1:0] sel);
    bus_write(1, reg_data_t'(sel));
    loop_now = sel;
  endtask

  // random ADC words and generator samples on both channels
  task automatic analog_burst(input int n, input string name);
    logic [31:0] r;
    int          ch;
    repeat (n) begin
      @(negedge adc_clk);
      for (ch = 0; ch < `RP_CHN; ch++) begin
        r = lcg_next();
        adc_dat_i[ch] = r[31:16];
        gen_dat_i[ch] = r[13:0];
        gen_vld_i[ch] = r[14];
        if (loop_now[ch]) begin
          expect_at(1, SIG_OSC + ch, {r[14], gen_to_osc(r[13:0])},
                    $sformatf("%s osc ch%0d", name, ch));
        end else begin
          expect_at(2, SIG_OSC + ch, {1'b1, adc_to_osc(r[31:16])},
                    $sformatf("%s osc ch%0d", name, ch));
          if (r[14]) begin
            dac_model[ch] = gen_to_dac(r[13:0]);
          end
        end
        // looped channel keeps its last code
        expect_at(1, SIG_DAC + ch, dac_model[ch], $sformatf("%s dac ch%0d", name, ch));
      end
    end
    // strobes off before the loop bits change
    @(negedge adc_clk);
    gen_vld_i = '0;
  endtask

  task automatic gpio_step(input gpio_vec_t iom);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    @(negedge adc_clk);
    r0 = lcg_next();
    r1 = lcg_next();
    gpio_o_i = r0[31:16];
    gpio_t_i = r0[15:0];
    lg_o_i   = r1[31:16];
    lg_e_i   = r1[15:0];
    r2 = lcg_next();
    exp_i_i  = r2[15:0];
    expect_at(1, SIG_EXP, {pin_select(iom, gpio_t_i, ~lg_e_i),
                           pin_select(iom, gpio_o_i, lg_o_i)}, "gpio exp_t exp_o");
    expect_at(2, SIG_GPI, exp_i_i, "gpio input");
  endtask

  // every level reaches every channel over four rounds
  task automatic pdm_round(input int round);
    logic [`RP_PDM_RNG-1:0] hist [`RP_PDM_CHN];
    int                     lvl [`RP_PDM_CHN];
    int                     ch;
    for (ch = 0; ch < `RP_PDM_CHN; ch++) begin
      lvl[ch]  = level_tab[(round + ch) % 4];
      hist[ch] = '0;
      bus_write(4 + ch, reg_data_t'(lvl[ch]));
    end
    // the write ends on the settling cycle
    repeat (`RP_PDM_RNG) begin
      @(negedge adc_clk);
      for (ch = 0; ch < `RP_PDM_CHN; ch++) begin
        hist[ch] = {hist[ch][`RP_PDM_RNG-2:0], pdm_o[ch]};
      end
    end
    for (ch = 0; ch < `RP_PDM_CHN; ch++) begin
      check_value($sformatf("pdm ch%0d level %0d", ch, lvl[ch]), lvl[ch],
                  count_ones(hist[ch]));
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : stimulus
    int        k;
    int        round;
    reg_data_t wd;
    gpio_vec_t iom;
    top_rst     = 1'b1;
    bus_wr_i    = 1'b0;
    bus_rd_i    = 1'b0;
    bus_addr_i  = REG_ID;
    bus_wdata_i = '0;
    adc_dat_i   = '0;
    gen_dat_i   = '0;
    gen_vld_i   = '0;
    gpio_o_i    = '0;
    gpio_t_i    = '1;
    lg_o_i      = '0;
    lg_e_i      = '0;
    exp_i_i     = '0;
    dac_model   = '{default: 14'd8191};
    // reset state, seen while reset is still held
    repeat (8) @(negedge adc_clk);
    check_value("reset osc_vld", '0, osc_vld_o);
    check_value("reset dac", {2{14'd8191}}, dac_dat_o);
    check_value("reset exp_t exp_o", {16'hffff, 16'h0000}, probe(SIG_EXP));
    check_value("reset pdm", '0, pdm_o);
    top_rst = 1'b0;
    bus_read(0, `RP_ID_VALUE, "id read");
    analog_burst(40, "adc path");
    set_loop(2'b01);
    analog_burst(30, "loop ch0");
    set_loop(2'b10);
    analog_burst(30, "loop ch1");
    set_loop(2'b00);
    analog_burst(10, "loop off");
    // whole map including the hole at 3
    repeat (2) begin
      for (k = 0; k < 8; k++) begin
        wd = lcg_next();
        bus_write(k, wd);
        bus_read(k, reg_expect(k, wd), $sformatf("reg read addr %0d", k));
      end
    end
    for (round = 0; round < 4; round++) begin
      wd  = lcg_next();
      iom = (round == 0) ? '0 : (round == 1) ? '1 : wd[15:0];
      bus_write(2, reg_data_t'(iom));
      repeat (20) gpio_step(iom);
    end
    for (round = 0; round < 4; round++) begin
      pdm_round(round);
    end
    while (due_q.size() != 0) begin
      @(negedge adc_clk);
    end
    $display("closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cyc >= TIMEOUT_CYCLES);
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("closing: %0d checks, %0d errors", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule : tb_rp_analog_top

/* verilog.f */
+incdir+hw
hw/rp_sample_pkg.sv
hw/rp_mgmt_pkg.sv
hw/osc_input_path.sv
hw/dac_output_path.sv
hw/mgmt_regs.sv
hw/exp_gpio_mux.sv
hw/pdm_dac.sv
hw/rp_analog_top.sv
tests/tb_rp_analog_top.sv
